/* verilog/bch_params.svh */
`ifndef BCH_PARAMS_SVH
`define BCH_PARAMS_SVH

// ============================================================
// binary BCH (15,5) code, corrects up to three errors
// ============================================================

`define BCH_N 15 // code length
`define BCH_K 5 // data bits
`define BCH_T 3 // correctable errors
`define BCH_M 4 // GF(2^M) element width

// g(x) = x^10 + x^8 + x^5 + x^4 + x^2 + x + 1
`define BCH_GEN 11'h537

// low terms of the primitive polynomial x^4 + x + 1
`define BCH_PRIM 4'h3

`endif

/* verilog/bch_pkg.sv */
`include "bch_params.svh"

package bch_pkg;

	typedef logic [`BCH_M-1:0] gf_elem_t;

	typedef enum logic [1:0] {ENC_IDLE, ENC_DATA, ENC_PARITY} enc_state_t;
	typedef enum logic [1:0] {LOC_IDLE, LOC_DISCREPANCY, LOC_UPDATE, LOC_DONE} loc_state_t;
	typedef enum logic {CHIEN_IDLE, CHIEN_SEARCH} chien_state_t;

	// ============================================================
	// GF(16) arithmetic
	// ============================================================

	function automatic gf_elem_t gf_mul(input gf_elem_t a, input gf_elem_t b);
		gf_elem_t p;
		gf_elem_t x;
		p = '0;
		x = a;
		for (int i = 0; i < `BCH_M; i++) begin
			if (b[i])
				p = p ^ x;
			x = {x[`BCH_M-2:0], 1'b0} ^ (x[`BCH_M-1] ? `BCH_PRIM : '0); // x * alpha
		end
		return p;
	endfunction

	function automatic gf_elem_t gf_square(input gf_elem_t a);
		return gf_mul(a, a);
	endfunction

	function automatic gf_elem_t gf_alpha_pow(input logic [3:0] e);
		gf_elem_t r;
		r = gf_elem_t'(1);
		for (int i = 0; i < `BCH_N; i++) begin
			if (i < e)
				r = gf_mul(r, gf_elem_t'(2));
		end
		return r;
	endfunction

endpackage

/* verilog/bch_encoder.sv */
`timescale 1ns/1ps
`include "bch_params.svh"

module bch_encoder (
	input logic clk,
	input logic reset,
	input logic start,
	input logic [`BCH_K-1:0] data_in,
	input logic accepted,
	output logic bit_out,
	output logic first,
	output logic penult,
	output logic last,
	output logic busy
);

	localparam int P = `BCH_N - `BCH_K; // parity bits

	bch_pkg::enc_state_t state;
	logic [3:0] cnt;
	logic [`BCH_K-1:0] data_sr;
	logic [P-1:0] lfsr;
	logic feedback;
	logic go;

	assign go = (state == bch_pkg::ENC_IDLE) && start && accepted;
	assign feedback = data_sr[0] ^ lfsr[P-1];

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= bch_pkg::ENC_IDLE;
			cnt <= '0;
		end else begin
			case (state)
			bch_pkg::ENC_IDLE: if (go) begin
				state <= bch_pkg::ENC_DATA;
				cnt <= '0;
			end
			bch_pkg::ENC_DATA: begin
				cnt <= cnt + 4'd1;
				if (cnt == 4'(`BCH_K - 1)) begin
					state <= bch_pkg::ENC_PARITY;
					cnt <= '0;
				end
			end
			default: begin
				cnt <= cnt + 4'd1;
				if (cnt == 4'(P - 1))
					state <= bch_pkg::ENC_IDLE;
			end
			endcase
		end
	end

	// data goes out while it is divided by g(x), the remainder follows
	always_ff @(posedge clk) begin
		if (go) begin
			data_sr <= data_in;
			lfsr <= '0;
		end else if (state == bch_pkg::ENC_DATA) begin
			data_sr <= {1'b0, data_sr[`BCH_K-1:1]};
			lfsr <= {lfsr[P-2:0], 1'b0} ^ (feedback ? P'(`BCH_GEN) : '0);
		end else if (state == bch_pkg::ENC_PARITY) begin
			lfsr <= {lfsr[P-2:0], 1'b0};
		end
	end

	assign bit_out = (state == bch_pkg::ENC_DATA) ? data_sr[0] :
		(state == bch_pkg::ENC_PARITY) && lfsr[P-1];
	assign first = (state == bch_pkg::ENC_DATA) && (cnt == 4'd0);
	assign penult = (state == bch_pkg::ENC_PARITY) && (cnt == 4'(P - 2));
	assign last = (state == bch_pkg::ENC_PARITY) && (cnt == 4'(P - 1));
	assign busy = (state != bch_pkg::ENC_IDLE) || !accepted;

endmodule

/* verilog/bch_syndrome.sv */
`timescale 1ns/1ps
`include "bch_params.svh"

module bch_syndrome (
	input logic clk,
	input logic reset,
	input logic start,
	input logic bit_in,
	input logic take,
	output logic done,
	output logic busy,
	output bch_pkg::gf_elem_t s1,
	output bch_pkg::gf_elem_t s3,
	output bch_pkg::gf_elem_t s5,
	output logic [`BCH_N-1:0] word
);

	logic collecting;
	logic step;
	logic [3:0] cnt;
	bch_pkg::gf_elem_t acc1;
	bch_pkg::gf_elem_t acc3;
	bch_pkg::gf_elem_t acc5;
	bch_pkg::gf_elem_t in_elem;

	assign step = start || collecting;
	assign in_elem = bch_pkg::gf_elem_t'(bit_in);

	always_ff @(posedge clk) begin
		if (reset) begin
			collecting <= 1'b0;
			done <= 1'b0;
			cnt <= '0;
		end else begin
			if (start) begin
				collecting <= 1'b1;
				cnt <= 4'd1; // bit 0 arrives with start
			end else if (collecting) begin
				cnt <= cnt + 4'd1;
				if (cnt == 4'(`BCH_N - 1)) begin
					collecting <= 1'b0;
					done <= 1'b1;
				end
			end
			if (take)
				done <= 1'b0;
		end
	end

	// Horner evaluation of r(x) at alpha, alpha^3 and alpha^5
	always_ff @(posedge clk) begin
		if (step) begin
			acc1 <= (start ? '0 : bch_pkg::gf_mul(acc1, bch_pkg::gf_alpha_pow(4'd1))) ^ in_elem;
			acc3 <= (start ? '0 : bch_pkg::gf_mul(acc3, bch_pkg::gf_alpha_pow(4'd3))) ^ in_elem;
			acc5 <= (start ? '0 : bch_pkg::gf_mul(acc5, bch_pkg::gf_alpha_pow(4'd5))) ^ in_elem;
			word <= {word[`BCH_N-2:0], bit_in}; // word[i] is the x^i coefficient
		end
	end

	assign s1 = acc1;
	assign s3 = acc3;
	assign s5 = acc5;
	assign busy = step || done;

endmodule

/* verilog/bch_locator.sv */
`timescale 1ns/1ps
`include "bch_params.svh"

module bch_locator (
	input logic clk,
	input logic reset,
	input logic load,
	input bch_pkg::gf_elem_t s1,
	input bch_pkg::gf_elem_t s3,
	input bch_pkg::gf_elem_t s5,
	input logic [`BCH_N-1:0] word_in,
	input logic take,
	output logic done,
	output logic busy,
	output bch_pkg::gf_elem_t sigma1,
	output bch_pkg::gf_elem_t sigma2,
	output bch_pkg::gf_elem_t sigma3,
	output logic [`BCH_N-1:0] word_out,
	output logic [1:0] degree
);

	bch_pkg::loc_state_t state;
	logic [1:0] iter;
	logic go;
	bch_pkg::gf_elem_t syn1, syn2, syn3, syn4, syn5;
	bch_pkg::gf_elem_t c1, c2, c3; // locator, c0 is always one
	bch_pkg::gf_elem_t bx1, bx2, bx3; // correction term x^m * B(x)
	bch_pkg::gf_elem_t b_prev; // last nonzero discrepancy
	bch_pkg::gf_elem_t d_reg;
	bch_pkg::gf_elem_t d_now;
	bch_pkg::gf_elem_t coef;
	logic [2:0] len; // register length L
	logic overflow;
	logic [`BCH_N-1:0] word_reg;

	// a^-1 = a^14 = a^8 * a^4 * a^2
	function automatic bch_pkg::gf_elem_t gf_inv(input bch_pkg::gf_elem_t a);
		bch_pkg::gf_elem_t a2;
		bch_pkg::gf_elem_t a4;
		bch_pkg::gf_elem_t a8;
		a2 = bch_pkg::gf_square(a);
		a4 = bch_pkg::gf_square(a2);
		a8 = bch_pkg::gf_square(a4);
		return bch_pkg::gf_mul(bch_pkg::gf_mul(a8, a4), a2);
	endfunction

	assign go = (state == bch_pkg::LOC_IDLE) && load;
	assign syn2 = bch_pkg::gf_square(syn1);
	assign syn4 = bch_pkg::gf_square(syn2);

	always_comb begin
		case (iter)
		2'd0: d_now = syn1;
		2'd1: d_now = syn3 ^ bch_pkg::gf_mul(c1, syn2) ^ bch_pkg::gf_mul(c2, syn1);
		default: d_now = syn5 ^ bch_pkg::gf_mul(c1, syn4) ^ bch_pkg::gf_mul(c2, syn3) ^
			bch_pkg::gf_mul(c3, syn2);
		endcase
	end

	assign coef = bch_pkg::gf_mul(d_reg, gf_inv(b_prev));

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= bch_pkg::LOC_IDLE;
			iter <= '0;
		end else begin
			case (state)
			bch_pkg::LOC_IDLE: if (go) begin
				state <= bch_pkg::LOC_DISCREPANCY;
				iter <= '0;
			end
			bch_pkg::LOC_DISCREPANCY: state <= bch_pkg::LOC_UPDATE;
			bch_pkg::LOC_UPDATE: begin
				if (iter == 2'(`BCH_T - 1)) begin
					state <= bch_pkg::LOC_DONE;
				end else begin
					iter <= iter + 2'd1;
					state <= bch_pkg::LOC_DISCREPANCY;
				end
			end
			default: if (take)
				state <= bch_pkg::LOC_IDLE;
			endcase
		end
	end

	// ============================================================
	// binary Berlekamp-Massey, even steps only
	// ============================================================
	always_ff @(posedge clk) begin
		if (go) begin
			syn1 <= s1;
			syn3 <= s3;
			syn5 <= s5;
			word_reg <= word_in;
			{c1, c2, c3} <= '0;
			{bx1, bx2, bx3} <= {bch_pkg::gf_elem_t'(1), 8'h00}; // B = 1, m = 1
			b_prev <= bch_pkg::gf_elem_t'(1);
			len <= '0;
		end else if (state == bch_pkg::LOC_DISCREPANCY) begin
			d_reg <= d_now;
		end else if (state == bch_pkg::LOC_UPDATE) begin
			if (d_reg != '0) begin
				c1 <= c1 ^ bch_pkg::gf_mul(coef, bx1);
				c2 <= c2 ^ bch_pkg::gf_mul(coef, bx2);
				c3 <= c3 ^ bch_pkg::gf_mul(coef, bx3);
			end
			if (d_reg != '0 && len <= 3'(iter)) begin
				bx1 <= '0; // B takes the old locator times x^2
				bx2 <= bch_pkg::gf_elem_t'(1);
				bx3 <= c1;
				b_prev <= d_reg;
				len <= {iter, 1'b1} - len;
			end else begin
				bx1 <= '0;
				bx2 <= '0;
				bx3 <= bx1;
			end
		end
	end

	// more than three errors: hand over sigma = 1, the search passes data through
	assign overflow = len > 3'(`BCH_T);
	assign sigma1 = overflow ? '0 : c1;
	assign sigma2 = overflow ? '0 : c2;
	assign sigma3 = overflow ? '0 : c3;
	assign degree = overflow ? 2'd0 : len[1:0];
	assign word_out = word_reg;
	assign done = (state == bch_pkg::LOC_DONE);
	assign busy = (state != bch_pkg::LOC_IDLE);

endmodule

/* verilog/bch_chien.sv */
`timescale 1ns/1ps
`include "bch_params.svh"

module bch_chien (
	input logic clk,
	input logic reset,
	input logic load,
	input bch_pkg::gf_elem_t sigma1,
	input bch_pkg::gf_elem_t sigma2,
	input bch_pkg::gf_elem_t sigma3,
	input logic [1:0] degree,
	input logic [`BCH_N-1:0] word,
	output logic busy,
	output logic output_valid,
	output logic bit_out
);

	bch_pkg::chien_state_t state;
	logic go;
	logic pass; // 0 counts roots, 1 emits
	logic [3:0] cnt;
	logic [1:0] roots;
	logic [1:0] deg_reg;
	logic root;
	logic [`BCH_N-1:0] word_reg;
	bch_pkg::gf_elem_t t1, t2, t3;

	assign go = (state == bch_pkg::CHIEN_IDLE) && load;
	assign root = (bch_pkg::gf_elem_t'(1) ^ t1 ^ t2 ^ t3) == '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= bch_pkg::CHIEN_IDLE;
			pass <= 1'b0;
			cnt <= '0;
			roots <= '0;
		end else if (go) begin
			state <= bch_pkg::CHIEN_SEARCH;
			pass <= 1'b0;
			cnt <= '0;
			roots <= '0;
		end else if (state == bch_pkg::CHIEN_SEARCH) begin
			cnt <= cnt + 4'd1;
			if (!pass && root)
				roots <= roots + 2'd1;
			if (cnt == 4'(`BCH_N - 1)) begin
				cnt <= '0;
				pass <= 1'b1;
				if (pass)
					state <= bch_pkg::CHIEN_IDLE;
			end
		end
	end

	// step t tests x = alpha^(t+1), the root for bit x^(14-t)
	// 15 steps bring terms and word back to their start value
	always_ff @(posedge clk) begin
		if (go) begin
			t1 <= bch_pkg::gf_mul(sigma1, bch_pkg::gf_alpha_pow(4'd1));
			t2 <= bch_pkg::gf_mul(sigma2, bch_pkg::gf_alpha_pow(4'd2));
			t3 <= bch_pkg::gf_mul(sigma3, bch_pkg::gf_alpha_pow(4'd3));
			word_reg <= word;
			deg_reg <= degree;
		end else if (state == bch_pkg::CHIEN_SEARCH) begin
			t1 <= bch_pkg::gf_mul(t1, bch_pkg::gf_alpha_pow(4'd1));
			t2 <= bch_pkg::gf_mul(t2, bch_pkg::gf_alpha_pow(4'd2));
			t3 <= bch_pkg::gf_mul(t3, bch_pkg::gf_alpha_pow(4'd3));
			word_reg <= {word_reg[`BCH_N-2:0], word_reg[`BCH_N-1]};
		end
	end

	assign output_valid = (state == bch_pkg::CHIEN_SEARCH) && pass && (cnt < 4'(`BCH_K));
	assign bit_out = word_reg[`BCH_N-1] ^ (root && (roots == deg_reg)); // flip only if consistent
	assign busy = (state != bch_pkg::CHIEN_IDLE);

endmodule

/* verilog/bch_loopback.sv */
`timescale 1ns/1ps
`include "bch_params.svh"

module bch_loopback (
	input logic clk,
	input logic reset,
	input logic encode_start,
	input logic [`BCH_K-1:0] data_in,
	input logic [`BCH_N-1:0] error,
	output logic busy,
	output logic encoded_penult,
	output logic output_valid,
	output logic wrong_now,
	output logic wrong,
	output logic [`BCH_K-1:0] data_out
);

	logic start_ok;
	logic enc_bit, enc_first, enc_last, enc_busy;
	logic chan_bit;
	logic syn_done, syn_busy;
	bch_pkg::gf_elem_t syn_s1, syn_s3, syn_s5;
	logic [`BCH_N-1:0] syn_word;
	logic loc_load, loc_done, loc_busy;
	bch_pkg::gf_elem_t loc_sigma1, loc_sigma2, loc_sigma3;
	logic [`BCH_N-1:0] loc_word;
	logic [1:0] loc_degree;
	logic chien_load, chien_busy;
	logic dec_bit;
	logic [`BCH_N-1:0] mask_sr;
	logic [`BCH_K-1:0] ref_cur, ref_syn, ref_loc, ref_chien, cmp_sr;
	logic last_valid;
	logic first_valid;
	logic exp_bit;
	logic new_wrong;

	assign busy = enc_busy || syn_busy;
	assign start_ok = encode_start && !busy;
	assign chan_bit = enc_bit ^ mask_sr[0]; // channel error injection
	assign loc_load = syn_done && !loc_busy;
	assign chien_load = loc_done && !chien_busy;

	bch_encoder u_encoder (
		.clk(clk), .reset(reset), .start(start_ok), .data_in(data_in),
		.accepted(!syn_busy), .bit_out(enc_bit), .first(enc_first),
		.penult(encoded_penult), .last(enc_last), .busy(enc_busy)
	);

	bch_syndrome u_syndrome (
		.clk(clk), .reset(reset), .start(enc_first), .bit_in(chan_bit), .take(loc_load),
		.done(syn_done), .busy(syn_busy), .s1(syn_s1), .s3(syn_s3), .s5(syn_s5),
		.word(syn_word)
	);

	bch_locator u_locator (
		.clk(clk), .reset(reset), .load(loc_load), .s1(syn_s1), .s3(syn_s3), .s5(syn_s5),
		.word_in(syn_word), .take(chien_load), .done(loc_done), .busy(loc_busy),
		.sigma1(loc_sigma1), .sigma2(loc_sigma2), .sigma3(loc_sigma3),
		.word_out(loc_word), .degree(loc_degree)
	);

	bch_chien u_chien (
		.clk(clk), .reset(reset), .load(chien_load), .sigma1(loc_sigma1),
		.sigma2(loc_sigma2), .sigma3(loc_sigma3), .degree(loc_degree), .word(loc_word),
		.busy(chien_busy), .output_valid(output_valid), .bit_out(dec_bit)
	);

	// ============================================================
	// reference words follow their codeword through the stages
	// ============================================================
	assign first_valid = output_valid && !last_valid;
	assign exp_bit = first_valid ? ref_chien[0] : cmp_sr[0];
	assign new_wrong = output_valid && (dec_bit != exp_bit);

	always_ff @(posedge clk) begin
		mask_sr <= start_ok ? error : {1'b0, mask_sr[`BCH_N-1:1]};
		if (start_ok)
			ref_cur <= data_in;
		if (enc_last)
			ref_syn <= ref_cur;
		if (loc_load)
			ref_loc <= ref_syn;
		if (chien_load)
			ref_chien <= ref_loc;
		if (first_valid)
			cmp_sr <= {1'b0, ref_chien[`BCH_K-1:1]};
		else if (output_valid)
			cmp_sr <= {1'b0, cmp_sr[`BCH_K-1:1]};
		if (output_valid)
			data_out <= {dec_bit, data_out[`BCH_K-1:1]}; // lsb arrives first
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			last_valid <= 1'b0;
			wrong_now <= 1'b0;
			wrong <= 1'b0;
		end else begin
			last_valid <= output_valid;
			wrong_now <= new_wrong;
			if (new_wrong)
				wrong <= 1'b1; // sticky
		end
	end

endmodule

/* testbench/bch_loopback_tb.sv */
`timescale 1ns/1ps
`include "bch_params.svh"

module bch_loopback_tb;

	localparam int clk_period = 8;
	localparam int reset_cycles = 5;
	localparam int exhaustive_words = 1 << `BCH_K;
	localparam int random_words = 60;
	localparam int overlap_words = 10;
	localparam int detect_words = 1;
	localparam int total_words = exhaustive_words + random_words + overlap_words + detect_words;
	localparam int cycles_per_word = 200;
	localparam int max_in_flight = 3; // one word each in syndrome, locator and search

	logic clk;
	logic reset;
	logic encode_start;
	logic [`BCH_K-1:0] data_in;
	logic [`BCH_N-1:0] error;
	logic busy;
	logic encoded_penult;
	logic output_valid;
	logic wrong_now;
	logic wrong;
	logic [`BCH_K-1:0] data_out;

	int checks;
	int errors;
	int test_errors_start;
	int unsigned seed_dummy;

	bch_loopback bch_loopback_i (
		.clk(clk), .reset(reset), .encode_start(encode_start), .data_in(data_in),
		.error(error), .busy(busy), .encoded_penult(encoded_penult),
		.output_valid(output_valid), .wrong_now(wrong_now), .wrong(wrong),
		.data_out(data_out)
	);

	always #(clk_period / 2) clk = ~clk;

	// ============================================================
	// helpers
	// ============================================================

	task automatic tick(); // inputs change and outputs are read 1 ns after the edge
		@(posedge clk);
		#1;
	endtask

	task automatic check(input string name, input logic [31:0] exp_val,
		input logic [31:0] got_val);
		checks++;
		if (exp_val !== got_val) begin
			errors++;
			$display("Mismatch %s exp %h got %h", name, exp_val, got_val);
		end
	endtask

	task automatic start_test();
		test_errors_start = errors;
	endtask

	task automatic report_test(input string name);
		if (errors == test_errors_start)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - test_errors_start);
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		repeat (reset_cycles) tick();
		reset = 1'b0;
		tick();
	endtask

	// weight distinct flipped bits among the first span transmitted bits
	function automatic logic [`BCH_N-1:0] random_mask(input int weight, input int span);
		logic [`BCH_N-1:0] m;
		int pos;
		m = '0;
		for (int i = 0; i < weight; i++) begin
			do
				pos = $urandom_range(span - 1, 0);
			while (m[pos]);
			m[pos] = 1'b1;
		end
		return m;
	endfunction

	task automatic send_word(input logic [`BCH_K-1:0] value, input logic [`BCH_N-1:0] mask);
		while (busy)
			tick();
		data_in = value;
		error = mask;
		encode_start = 1'b1;
		tick();
		encode_start = 1'b0;
		// bit k of the codeword is on the line k cycles after the start edge
		for (int k = 1; k <= `BCH_N; k++) begin
			check("encoded_penult", (k == `BCH_N - 1), encoded_penult);
			tick();
		end
		while (!output_valid)
			tick();
		while (output_valid)
			tick(); // data_out is complete once valid has fallen
	endtask

	// ============================================================
	// tests
	// ============================================================

	task automatic test_reset_state();
		start_test();
		check("busy", 0, busy);
		check("output_valid", 0, output_valid);
		check("wrong", 0, wrong);
		check("wrong_now", 0, wrong_now);
		report_test("reset_state");
	endtask

	task automatic test_error_free();
		start_test();
		for (int v = 0; v < exhaustive_words; v++) begin
			send_word(v[`BCH_K-1:0], '0);
			check("data_out", v, data_out);
			check("wrong", 0, wrong);
		end
		report_test("error_free");
	endtask

	task automatic test_correction();
		logic [`BCH_K-1:0] value;
		start_test();
		for (int i = 0; i < random_words; i++) begin
			value = $urandom_range(exhaustive_words - 1, 0);
			send_word(value, random_mask($urandom_range(`BCH_T, 1), `BCH_N));
			check("data_out", value, data_out);
			check("wrong", 0, wrong);
		end
		report_test("correction");
	endtask

	task automatic test_overlap();
		logic [`BCH_K-1:0] expected[$];
		logic [`BCH_K-1:0] value;
		logic prev_valid;
		int issued;
		int done_count;
		start_test();
		issued = 0;
		done_count = 0;
		prev_valid = 1'b0;
		while (done_count < overlap_words) begin
			tick();
			if (encode_start) begin // taken by the edge just passed
				encode_start = 1'b0;
				issued++;
			end
			if (prev_valid && !output_valid) begin
				if (expected.size() == 0) begin
					errors++;
					$display("output word appeared with no word issued");
				end else begin
					check("data_out", expected.pop_front(), data_out);
				end
				done_count++;
			end
			prev_valid = output_valid;
			if (issued - done_count > max_in_flight) begin
				errors++;
				$display("too many words in flight: %0d", issued - done_count);
			end
			if (issued < overlap_words && !busy) begin
				value = $urandom_range(exhaustive_words - 1, 0);
				expected.push_back(value);
				data_in = value;
				error = random_mask($urandom_range(`BCH_T, 1), `BCH_N);
				encode_start = 1'b1;
			end
		end
		check("wrong", 0, wrong);
		report_test("overlap");
	endtask

	task automatic test_detection();
		start_test();
		// four flips inside the data bits always leave a data bit wrong
		send_word($urandom_range(exhaustive_words - 1, 0), random_mask(4, `BCH_K));
		check("wrong", 1, wrong);
		apply_reset();
		check("wrong", 0, wrong);
		report_test("detection");
	endtask

	// ============================================================
	// main sequence and watchdog
	// ============================================================

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		encode_start = 1'b0;
		data_in = '0;
		error = '0;
		checks = 0;
		errors = 0;
		test_errors_start = 0;
		seed_dummy = $urandom(32'h95f5_1cc0);
		apply_reset();
		test_reset_state();
		test_error_free();
		test_correction();
		test_overlap();
		test_detection();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	initial begin
		#(total_words * cycles_per_word * clk_period);
		$display("timeout: output_valid never finished");
		$display("=== FAIL ===");
		$finish;
	end

endmodule

/* src.f */
+incdir+verilog
verilog/bch_pkg.sv
verilog/bch_encoder.sv
verilog/bch_syndrome.sv
verilog/bch_locator.sv
verilog/bch_chien.sv
verilog/bch_loopback.sv
testbench/bch_loopback_tb.sv

/* Makefile */
SIM = obj_dir/Vbch_loopback_tb
SRCS = $(shell grep -v '^+' src.f) verilog/bch_params.svh

all: run

$(SIM): src.f $(SRCS)
	verilator --binary --timing -Wno-fatal -f src.f --top-module bch_loopback_tb

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
